//--- flist.f
l2_tlb_pkg.sv
tlb_entry_ram.sv
tlb_check_ram.sv
l2_tlb_ctrl.sv
l2_tlb.sv
tb_l2_tlb_assert.sv
tb_l2_tlb.sv

//--- run.sh
#!/bin/sh
# Build and run the L2 TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_l2_tlb -o sim_tb_l2_tlb

# The simulator exits non-zero on a failure, the log decides the result
./obj_dir/sim_tb_l2_tlb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation PASSED"

//--- tb_l2_tlb.sv
// Self-checking testbench of the L2 TLB lookup subsystem
// Walks empty-table misses, known hits, protection, multi-hit, back-pressure and a random mix
// A shadow table and a reference lookup give the expected response of every request

`timescale 1ns/1ps

module tb_l2_tlb;

   import l2_tlb_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int N_CLEAR    = 2**IDX_WIDTH;  // Clear writes at start
   localparam int N_EMPTY    = 8;
   localparam int N_KNOWN    = 8;
   localparam int N_PROT     = 4;
   localparam int N_BP       = 6;
   localparam int N_MIX      = 80;
   localparam int N_OPS      = N_CLEAR + N_EMPTY + 2*N_KNOWN + 3*N_PROT + 3 + N_BP + N_MIX;

   logic       clk_i = 1'b0;
   logic       rst_ni;
   logic       req_valid;
   logic       req_ready;
   tlb_req_t   req;
   logic       rsp_valid;
   logic       rsp_ready;
   tlb_rsp_t   rsp;
   logic       wr_valid;
   logic       wr_ready;
   tlb_wr_t    wr;

   tlb_entry_t shadow [2**IDX_WIDTH];  // Mirror of the RAM contents
   tlb_rsp_t   exp_q [$];              // Expected responses in order
   logic [15:0] lfsr_q = 16'd42058;
   string      test_name = "reset";
   string      rsp_name;               // Phase of the lookup in flight
   logic       pending_q;              // Lookup accepted and its response not yet sent
   logic       stall_q;
   tlb_rsp_t   stall_rsp_q;
   vpn_t       known_vpn [N_KNOWN];

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   l2_tlb u_l2_tlb (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .req_i       (req),
      .rsp_valid_o (rsp_valid),
      .rsp_ready_i (rsp_ready),
      .rsp_o       (rsp),
      .wr_valid_i  (wr_valid),
      .wr_ready_o  (wr_ready),
      .wr_i        (wr)
   );

   bind l2_tlb tb_l2_tlb_assert u_assert (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_ready_o (req_ready_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_o       (rsp_o)
   );

   // Galois LFSR with polynomial x^16+x^14+x^13+x^11+1 and one step per bit taken
   function automatic logic [31:0] rand_bits(input int unsigned n);
      logic [31:0] val;
      val = '0;
      for (int unsigned i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
         val    = {val[30:0], lfsr_q[0]};
      end
      return val;
   endfunction

   // Small VPN pool so the random mix finds hits
   function automatic vpn_t pool_vpn();
      return {16'h00A5, 4'(rand_bits(4))};
   endfunction

   function automatic tlb_entry_t rand_entry();
      tlb_entry_t e;
      e.vpn    = pool_vpn();
      e.master = 1'(rand_bits(1));
      e.wr_ok  = 1'(rand_bits(1));
      e.rd_ok  = 1'(rand_bits(1));
      e.valid  = 1'(rand_bits(2) != 0);  // Mostly valid
      return e;
   endfunction

   // Reference lookup scans the offsets in order and bank 0 before bank 1
   function automatic tlb_rsp_t ref_lookup(input tlb_req_t rq);
      tlb_rsp_t   r;
      vpn_t       vpn;
      set_idx_t   set;
      tlb_entry_t e0;
      tlb_entry_t e1;
      tlb_entry_t e;
      logic       h0;
      logic       h1;
      r   = '0;
      vpn = rq.vaddr[VA_WIDTH-1:PAGE_BITS];
      set = vpn[SET_WIDTH-1:0];
      for (int o = 0; o < NUM_OFFSETS; o++) begin
         e0 = shadow[{1'b0, set, offset_idx_t'(o)}];
         e1 = shadow[{1'b1, set, offset_idx_t'(o)}];
         h0 = e0.valid && (e0.vpn == vpn);
         h1 = e1.valid && (e1.vpn == vpn);
         if (h0 || h1) begin
            e           = h0 ? e0 : e1;
            r.hit       = 1'b1;
            r.multi_hit = h0 && h1;
            r.master    = e.master;
            r.prot      = rq.is_write ? !e.wr_ok : !e.rd_ok;
            r.hit_idx   = {!h0, set, offset_idx_t'(o)};
            return r;
         end
      end
      return r;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_rsp(input string name, input tlb_rsp_t exp, input tlb_rsp_t act);
      if (exp !== act) begin
         fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
      end
   endtask

   // Entry write that is accepted on the next edge
   task automatic write_entry(input entry_idx_t idx, input tlb_entry_t e);
      wr_valid <= 1'b1;
      wr       <= {idx, e};
      @(posedge clk_i);
      wr_valid <= 1'b0;
   endtask

   // One lookup with optional stall cycles and writes to other sets during the walk
   task automatic lookup(input tlb_req_t rq, input int hold, input bit walk_writes);
      set_idx_t req_set;
      int       stalled;
      bit       done;
      tlb_wr_t  w;
      req_valid <= 1'b1;
      req       <= rq;
      rsp_ready <= (hold == 0);
      do @(posedge clk_i); while (!req_ready);
      exp_q.push_back(ref_lookup(rq));
      req_valid <= 1'b0;
      req_set   = rq.vaddr[PAGE_BITS +: SET_WIDTH];
      stalled   = 0;
      done      = 0;
      while (!done) begin
         if (walk_writes && rand_bits(1) != 0) begin
            // Writes avoid the set under lookup so the expected result stays fixed
            w.idx   = {1'(rand_bits(1)), req_set ^ {2'(rand_bits(2)), 1'b1},
                       offset_idx_t'(rand_bits(2))};
            w.entry = rand_entry();
            wr_valid <= 1'b1;
            wr       <= w;
         end else begin
            wr_valid <= 1'b0;
         end
         @(posedge clk_i);
         if (rsp_valid) begin
            if (rsp_ready) begin
               done = 1;
            end else begin
               stalled++;
               if (stalled >= hold) rsp_ready <= 1'b1;
            end
         end
      end
      wr_valid  <= 1'b0;
      rsp_ready <= 1'b1;
   endtask

   always @(posedge clk_i) begin
      if (wr_valid && wr_ready) shadow[wr.idx] <= wr.entry;
   end

   // Response checker
   always @(posedge clk_i) begin
      if (!rst_ni) begin
         pending_q = 1'b0;
         stall_q   = 1'b0;
      end else begin
         if (wr_valid && !wr_ready) fail_run("write port not ready for an entry write");
         if (pending_q && req_ready) fail_run("request port ready while a lookup was pending");
         if (stall_q) begin
            if (!rsp_valid) fail_run("response valid dropped before the handshake");
            check_rsp({rsp_name, " stall"}, stall_rsp_q, rsp);
         end
         if (req_valid && req_ready) begin
            pending_q = 1'b1;
            rsp_name  = test_name;
         end
         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) fail_run("response without an accepted request");
            check_rsp(rsp_name, exp_q.pop_front(), rsp);
            pending_q = 1'b0;
         end
         stall_q     = rsp_valid && !rsp_ready;
         stall_rsp_q = rsp;
      end
   end

   initial begin
      #(N_OPS * 20 * CLK_PERIOD);
      $display("Timeout: the tests did not finish in time");
      $display("Testbench failed");
      $fatal(1);
   end

   initial begin
      tlb_entry_t e;
      tlb_req_t   rq;
      vpn_t       v;
      entry_idx_t idx;
      rst_ni    = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b1;
      wr_valid  = 1'b0;
      wr        = '0;
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);

      test_name = "clear";
      for (int i = 0; i < N_CLEAR; i++) write_entry(entry_idx_t'(i), '0);

      test_name = "empty miss";
      for (int i = 0; i < N_EMPTY; i++) lookup({rand_bits(32), 1'(rand_bits(1))}, 0, 0);

      test_name = "known hit";
      for (int i = 0; i < N_KNOWN; i++) begin
         v            = vpn_t'(rand_bits(VPN_WIDTH));
         known_vpn[i] = v;
         idx          = {1'(rand_bits(1)), v[SET_WIDTH-1:0], offset_idx_t'(rand_bits(2))};
         write_entry(idx, '{vpn: v, master: 1'(rand_bits(1)), wr_ok: 1'b1, rd_ok: 1'b1,
                            valid: 1'b1});
      end
      for (int i = 0; i < N_KNOWN; i++) begin
         lookup({known_vpn[i], 12'(rand_bits(12)), 1'(rand_bits(1))}, 0, 0);
      end

      test_name = "protection";
      for (int k = 0; k < N_PROT; k++) begin
         v   = vpn_t'(rand_bits(VPN_WIDTH));
         idx = {1'b0, v[SET_WIDTH-1:0], offset_idx_t'(k)};
         write_entry(idx, '{vpn: v, master: 1'b0, wr_ok: k[0], rd_ok: k[1], valid: 1'b1});
         lookup({v, 12'h0, 1'b0}, 0, 0);  // Read access
         lookup({v, 12'h0, 1'b1}, 0, 0);  // Write access
      end

      test_name = "multi hit";
      v = vpn_t'(rand_bits(VPN_WIDTH));
      e = '{vpn: v, master: 1'b1, wr_ok: 1'b1, rd_ok: 1'b1, valid: 1'b1};
      write_entry({1'b0, v[SET_WIDTH-1:0], 2'd2}, e);
      write_entry({1'b1, v[SET_WIDTH-1:0], 2'd2}, e);
      lookup({v, 12'h0, 1'b0}, 0, 0);

      test_name = "back pressure";
      for (int i = 0; i < N_BP; i++) begin
         lookup({known_vpn[i], 12'h0, 1'b0}, 1 + int'(rand_bits(3)), 0);
      end

      test_name = "random mix";
      for (int i = 0; i < N_MIX; i++) begin
         if (rand_bits(1) != 0) begin
            write_entry(entry_idx_t'(rand_bits(IDX_WIDTH)), rand_entry());
         end else begin
            rq.vaddr    = {pool_vpn(), 12'(rand_bits(12))};
            rq.is_write = 1'(rand_bits(1));
            lookup(rq, (rand_bits(2) == 3) ? 2 : 0, 1);
         end
      end

      @(posedge clk_i);
      if (exp_q.size() == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- tb_l2_tlb_assert.sv
// Concurrent protocol checks for the L2 TLB top level
// Bound onto l2_tlb from the testbench, reports through failing assertions only

`timescale 1ns/1ps

module tb_l2_tlb_assert (
   input logic                 clk_i,
   input logic                 rst_ni,
   input logic                 req_ready_o,
   input logic                 rsp_valid_o,
   input logic                 rsp_ready_i,
   input l2_tlb_pkg::tlb_rsp_t rsp_o
);

   // Stalled response keeps valid and payload
   a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
      else $error("response changed or dropped under back-pressure");

   // One lookup in flight
   a_req_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_valid_o |-> !req_ready_o)
      else $error("request port ready while a response is pending");

   a_flags_need_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (rsp_o.multi_hit || rsp_o.prot) |-> rsp_o.hit)
      else $error("multi_hit or prot raised without hit");

   a_quiet_in_reset: assert property (@(posedge clk_i)
      !rst_ni |-> !rsp_valid_o)
      else $error("response valid during reset");

endmodule

//--- l2_tlb.sv
// Top level of the L2 TLB lookup subsystem
// Lookup request and response use valid/ready; the entry write port is always ready
// Controller walks the set, compare block forms the response, RAM holds both banks

`timescale 1ns/1ps

module l2_tlb (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   // Lookup request
   input  logic                 req_valid_i,
   output logic                 req_ready_o,
   input  l2_tlb_pkg::tlb_req_t req_i,
   // Lookup response
   output logic                 rsp_valid_o,
   input  logic                 rsp_ready_i,
   output l2_tlb_pkg::tlb_rsp_t rsp_o,
   // Entry write
   input  logic                 wr_valid_i,
   output logic                 wr_ready_o,
   input  l2_tlb_pkg::tlb_wr_t  wr_i
);

   import l2_tlb_pkg::*;

   logic        ram_we;
   entry_idx_t  port0_addr;
   entry_idx_t  port1_addr;
   tlb_entry_t  ram_wdata;
   tlb_entry_t  rdata0;     // Bank 0 read word
   tlb_entry_t  rdata1;     // Bank 1 read word
   logic        out_valid;
   logic        rsp_sent;
   tlb_req_t    req_q;
   offset_idx_t offset_q;

   l2_tlb_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_valid_i  (req_valid_i),
      .req_ready_o  (req_ready_o),
      .req_i        (req_i),
      .wr_valid_i   (wr_valid_i),
      .wr_ready_o   (wr_ready_o),
      .wr_i         (wr_i),
      .rsp_ready_i  (rsp_ready_i),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_hit_i    (rsp_o.hit),
      .ram_we_o     (ram_we),
      .port0_addr_o (port0_addr),
      .port1_addr_o (port1_addr),
      .ram_wdata_o  (ram_wdata),
      .out_valid_o  (out_valid),
      .rsp_sent_o   (rsp_sent),
      .req_o        (req_q),
      .offset_o     (offset_q)
   );

   tlb_check_ram u_check (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .out_valid_i (out_valid),
      .rsp_sent_i  (rsp_sent),
      .req_i       (req_q),
      .offset_i    (offset_q),
      .rdata0_i    (rdata0),
      .rdata1_i    (rdata1),
      .rsp_o       (rsp_o)
   );

   tlb_entry_ram u_ram (
      .clk_i    (clk_i),
      .we_i     (ram_we),
      .addr0_i  (port0_addr),
      .addr1_i  (port1_addr),
      .wdata_i  (ram_wdata),
      .rdata0_o (rdata0),
      .rdata1_o (rdata1)
   );

endmodule

//--- l2_tlb_ctrl.sv
// Lookup controller of the L2 TLB
// Accepts one lookup at a time and walks the offsets of its set, one read per cycle
// Entry writes are always accepted and take the RAM, pushing the next read back a cycle
// A response is raised in the compare cycle of a hit or of the last offset

`timescale 1ns/1ps

module l2_tlb_ctrl (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   // Lookup request
   input  logic                    req_valid_i,
   output logic                    req_ready_o,
   input  l2_tlb_pkg::tlb_req_t    req_i,
   // Entry write
   input  logic                    wr_valid_i,
   output logic                    wr_ready_o,
   input  l2_tlb_pkg::tlb_wr_t     wr_i,
   // Response handshake, payload comes from the compare block
   input  logic                    rsp_ready_i,
   output logic                    rsp_valid_o,
   input  logic                    rsp_hit_i,
   // RAM
   output logic                    ram_we_o,
   output l2_tlb_pkg::entry_idx_t  port0_addr_o,
   output l2_tlb_pkg::entry_idx_t  port1_addr_o,
   output l2_tlb_pkg::tlb_entry_t  ram_wdata_o,
   // Compare block
   output logic                    out_valid_o,
   output logic                    rsp_sent_o,
   output l2_tlb_pkg::tlb_req_t    req_o,
   output l2_tlb_pkg::offset_idx_t offset_o
);

   import l2_tlb_pkg::*;

   localparam offset_idx_t LAST_OFFSET = offset_idx_t'(NUM_OFFSETS - 1);

   typedef enum logic [1:0] {
      IDLE,
      WALK,
      RESP
   } ctrl_state_e;

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   tlb_req_t    req_q;        // Accepted lookup
   offset_idx_t rd_off_q;     // Next offset to read
   offset_idx_t prev_off_q;   // Offset read in the previous cycle
   logic        rd_pend_q;    // Offsets left to read
   logic        out_valid_q;  // A read was issued last cycle
   set_idx_t    req_set;
   logic        req_hs;
   logic        cmp_end;
   logic        issue;

   assign req_set = req_q.vaddr[PAGE_BITS +: SET_WIDTH];

   assign req_hs  = req_valid_i && (state_q == IDLE);
   // Walk ends on a hit or once the last offset has been compared
   assign cmp_end = out_valid_q && (rsp_hit_i || (prev_off_q == LAST_OFFSET));
   // Writes have priority over the RAM
   assign issue   = (state_q == WALK) && rd_pend_q && !wr_valid_i && !cmp_end;

   // Main FSM
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (req_hs) begin
               state_d = WALK;
            end
         end
         WALK: begin
            if (cmp_end) begin
               state_d = rsp_ready_i ? IDLE : RESP;  // Immediate handshake skips RESP
            end
         end
         RESP: begin
            if (rsp_ready_i) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q     <= IDLE;
         rd_off_q    <= '0;
         prev_off_q  <= '0;
         rd_pend_q   <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         out_valid_q <= issue;
         if (req_hs) begin
            rd_off_q  <= '0;    // Walk starts at offset 0
            rd_pend_q <= 1'b1;
         end else if (issue) begin
            rd_off_q   <= rd_off_q + offset_idx_t'(1);
            prev_off_q <= rd_off_q;
            if (rd_off_q == LAST_OFFSET) begin
               rd_pend_q <= 1'b0;  // All offsets issued
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_hs) begin
         req_q <= req_i;
      end
   end

   // Handshakes
   assign req_ready_o = (state_q == IDLE);
   assign wr_ready_o  = 1'b1;
   assign rsp_valid_o = (state_q == RESP) || ((state_q == WALK) && cmp_end);
   assign rsp_sent_o  = rsp_valid_o && rsp_ready_i;

   // RAM side, same offset in both banks
   assign ram_we_o     = wr_valid_i;
   assign port0_addr_o = wr_valid_i ? wr_i.idx : {1'b0, req_set, rd_off_q};
   assign port1_addr_o = {1'b1, req_set, rd_off_q};
   assign ram_wdata_o  = wr_i.entry;

   // Compare block side
   assign out_valid_o = out_valid_q;
   assign req_o       = req_q;
   assign offset_o    = prev_off_q;

endmodule

//--- tlb_check_ram.sv
// Compare stage of the L2 TLB walk
// Matches both RAM bank outputs against the request VPN while out_valid_i is high
// A hit is presented in the compare cycle and then held until the response is sent
// Bank 0 wins when both banks match; that case also raises multi_hit

`timescale 1ns/1ps

module tlb_check_ram (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  logic                    out_valid_i,  // RAM outputs come from a real read
   input  logic                    rsp_sent_i,   // Response handshake this cycle
   input  l2_tlb_pkg::tlb_req_t    req_i,        // Request under lookup, held by the controller
   input  l2_tlb_pkg::offset_idx_t offset_i,     // Offset of the read being compared
   input  l2_tlb_pkg::tlb_entry_t  rdata0_i,
   input  l2_tlb_pkg::tlb_entry_t  rdata1_i,
   output l2_tlb_pkg::tlb_rsp_t    rsp_o
);

   import l2_tlb_pkg::*;

   typedef enum logic {
      SEARCH,
      HOLD_HIT
   } hit_state_e;

   hit_state_e hit_state_q;
   hit_state_e hit_state_d;

   vpn_t       req_vpn;
   set_idx_t   req_set;
   logic       bank0_hit;
   logic       bank1_hit;
   logic       live_hit;
   tlb_entry_t hit_entry;
   tlb_rsp_t   live_rsp;
   tlb_rsp_t   held_rsp;    // Captured result while waiting for the handshake

   assign req_vpn = req_i.vaddr[VA_WIDTH-1:PAGE_BITS];
   assign req_set = req_vpn[SET_WIDTH-1:0];  // Set taken from the low VPN bits

   // Per-bank tag match
   assign bank0_hit = rdata0_i.valid && (rdata0_i.vpn == req_vpn);
   assign bank1_hit = rdata1_i.valid && (rdata1_i.vpn == req_vpn);
   assign live_hit  = out_valid_i && (bank0_hit || bank1_hit);

   assign hit_entry = bank0_hit ? rdata0_i : rdata1_i;  // Bank 0 priority

   // Result of the current compare, all zero when nothing matches
   always_comb begin
      live_rsp = '0;
      if (live_hit) begin
         live_rsp.hit       = 1'b1;
         live_rsp.multi_hit = bank0_hit && bank1_hit;
         live_rsp.master    = hit_entry.master;
         live_rsp.hit_idx   = {~bank0_hit, req_set, offset_i};  // Bank bit set only for bank 1

         // Access type must be allowed by the matching entry
         if (req_i.is_write) begin
            live_rsp.prot = ~hit_entry.wr_ok;
         end else begin
            live_rsp.prot = ~hit_entry.rd_ok;
         end
      end
   end

   // Hit FSM
   always_comb begin
      hit_state_d = hit_state_q;
      unique case (hit_state_q)
         SEARCH: begin
            // Hit sent in its own cycle needs no holding
            if (live_hit && !rsp_sent_i) begin
               hit_state_d = HOLD_HIT;
            end
         end
         HOLD_HIT: begin
            if (rsp_sent_i) begin
               hit_state_d = SEARCH;  // Release for the next lookup
            end
         end
         default: begin
            hit_state_d = SEARCH;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         hit_state_q <= SEARCH;
      end else begin
         hit_state_q <= hit_state_d;
      end
   end

   // RAM outputs move on after the compare cycle, so keep a copy
   always_ff @(posedge clk_i) begin
      if ((hit_state_q == SEARCH) && live_hit) begin
         held_rsp <= live_rsp;
      end
   end

   assign rsp_o = (hit_state_q == HOLD_HIT) ? held_rsp : live_rsp;

endmodule

//--- tlb_entry_ram.sv
// Dual-port entry table of the L2 TLB, maps onto one block RAM
// Port 0 doubles as the write port; a write cycle issues no read
// Read data is registered and keeps its old value across a write cycle

`timescale 1ns/1ps

module tlb_entry_ram (
   input  logic                   clk_i,
   input  logic                   we_i,
   input  l2_tlb_pkg::entry_idx_t addr0_i,   // Write address or bank 0 read address
   input  l2_tlb_pkg::entry_idx_t addr1_i,   // Bank 1 read address
   input  l2_tlb_pkg::tlb_entry_t wdata_i,
   output l2_tlb_pkg::tlb_entry_t rdata0_o,
   output l2_tlb_pkg::tlb_entry_t rdata1_o
);

   import l2_tlb_pkg::*;

   tlb_entry_t mem [2**IDX_WIDTH];  // 64 entries, both banks

   // No-change mode, outputs stall during writes
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr0_i] <= wdata_i;
      end else begin
         rdata0_o <= mem[addr0_i];
         rdata1_o <= mem[addr1_i];
      end
   end

endmodule

//--- l2_tlb_pkg.sv
// Shared widths, index types and bus structs of the L2 TLB lookup subsystem
// Import this package inside module bodies; use scoped names in port lists
// Entry index layout is {bank, set, offset}, bank 0 in the lower half of the RAM

package l2_tlb_pkg;

   // Address split
   localparam int unsigned VA_WIDTH     = 32;
   localparam int unsigned PAGE_BITS    = 12;                    // 4 KiB pages
   localparam int unsigned VPN_WIDTH    = VA_WIDTH - PAGE_BITS;  // 20

   // Table geometry
   localparam int unsigned SET_WIDTH    = 3;                     // 8 sets
   localparam int unsigned OFFSET_WIDTH = 2;                     // Ways per bank and set
   localparam int unsigned NUM_OFFSETS  = 1 << OFFSET_WIDTH;     // 4
   localparam int unsigned IDX_WIDTH    = 1 + SET_WIDTH + OFFSET_WIDTH; // Bank bit on top

   typedef logic [VPN_WIDTH-1:0]    vpn_t;
   typedef logic [SET_WIDTH-1:0]    set_idx_t;
   typedef logic [OFFSET_WIDTH-1:0] offset_idx_t;
   typedef logic [IDX_WIDTH-1:0]    entry_idx_t;

   // One page entry as stored in the RAM
   typedef struct packed {
      vpn_t vpn;
      logic master;     // Master page flag, returned on a hit
      logic wr_ok;      // Write access allowed
      logic rd_ok;      // Read access allowed
      logic valid;
   } tlb_entry_t;

   // Lookup request
   typedef struct packed {
      logic [VA_WIDTH-1:0] vaddr;
      logic                is_write;  // 1 for a write access, 0 for a read
   } tlb_req_t;

   // Entry write, always accepted
   typedef struct packed {
      entry_idx_t idx;
      tlb_entry_t entry;
   } tlb_wr_t;

   // Lookup response
   typedef struct packed {
      logic       hit;
      logic       multi_hit;  // Both banks matched at the hit offset
      logic       prot;       // Access type not allowed by the hit entry
      logic       master;
      entry_idx_t hit_idx;
   } tlb_rsp_t;

endpackage
